/* Makefile */
# Verilator build and run for the packet switch

VERILATOR   ?= verilator
TOP         ?= switch_tb
FILELIST    ?= verilog.f
OBJ_DIR     ?= obj_dir
ERROR_LIMIT ?= 1000
VFLAGS      ?= --binary --timing --assert
PASS_MSG    := Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the result is decided by the pass line in the simulation output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP) +verilator+error+limit+$(ERROR_LIMIT) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* common/packet_pkg.sv */
`default_nettype none

`include "switch_defs.svh"

// packet format shared by FIFOs, port controllers and the crossbar
package packet_pkg;

	// top two bits of every packet
	typedef enum logic [1:0] {
		DATA = 2'b00, // unicast or multicast to target mask
		BDP  = 2'b01, // broadcast to all but the source
		CTRL = 2'b10, // routed exactly like DATA
		RSVD = 2'b11  // never routed, always dropped
	} pkt_type_t;

	// header is the low byte, target over source
	typedef struct packed {
		pkt_type_t              ptype;
		logic [`PKT_WIDTH-2-2*`NUM_PORTS-1:0] payload;
		logic [`NUM_PORTS-1:0]  target;
		logic [`NUM_PORTS-1:0]  source;
	} packet_t;

endpackage

`default_nettype wire

/* common/port_if.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// one instance per port
// links a port controller to the arbiter and the crossbar
interface port_if import packet_pkg::*; ();

	// port wants the output bus
	logic                  req;
	// effective destination, already expanded for broadcast
	logic [`NUM_PORTS-1:0] dest;
	// packet sitting at the FIFO head
	packet_t               pkt;
	// combinational grant back from the arbiter
	logic                  grant;

	// port controller side
	modport ctrl (
		output req,
		output dest,
		output pkt,
		input  grant
	);

	// arbiter only looks at requests
	modport arb (
		input  req,
		output grant
	);

	// crossbar picks up the granted packet
	modport xbar (
		input dest,
		input pkt,
		input grant
	);

endinterface

`default_nettype wire

/* common/switch_ctrl_pkg.sv */
`default_nettype none

// control types of the port controllers
package switch_ctrl_pkg;

	// per-port FSM
	// IDLE      wait for a packet at the FIFO head
	// ROUTE     one cycle of header decode, drop or request
	// ARB_WAIT  req held high until the arbiter grants
	// TRANSMIT  one cycle after the grant, head already popped
	typedef enum logic [1:0] {
		IDLE     = 2'd0,
		ROUTE    = 2'd1,
		ARB_WAIT = 2'd2,
		TRANSMIT = 2'd3
	} state_t;

endpackage

`default_nettype wire

/* common/switch_defs.svh */
`ifndef SWITCH_DEFS_SVH
`define SWITCH_DEFS_SVH

// ==================================================
// switch sizing
// ==================================================

// number of switch ports, one input FIFO and one output each
`define NUM_PORTS 4

// entries per input FIFO, must stay a power of two
`define FIFO_DEPTH 8

// one packet is one word
`define PKT_WIDTH 16

// longest wait in cycles from req to grant for any port
`define FAIR_BOUND 20

`endif

/* port/packet_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// per-port input FIFO
// circular buffer, head is read combinationally from memory
module packet_fifo import packet_pkg::*; (
	input  wire logic       clk,
	input  wire logic       rst_n,
	input  wire logic       wr_en,
	input  wire packet_t    wr_data,
	input  wire logic       rd_en,
	output packet_t         rd_data,
	output logic            empty,
	output logic            full,
	output logic [3:0]      count
);

	localparam int PTR_W = $clog2(`FIFO_DEPTH);
	localparam int CNT_W = PTR_W + 1;
	localparam logic [CNT_W-1:0] DEPTH_CNT = CNT_W'(`FIFO_DEPTH);

	// storage
	packet_t mem [`FIFO_DEPTH];

	logic [PTR_W-1:0] wr_ptr;
	logic [PTR_W-1:0] rd_ptr;

	// qualified strobes
	logic wr_ok;
	logic rd_ok;
	logic [CNT_W-1:0] count_next;

	// write ignored when full, read ignored when empty
	assign wr_ok = wr_en && !full;
	assign rd_ok = rd_en && !empty;

	// occupancy after this edge
	assign count_next = count + CNT_W'(wr_ok) - CNT_W'(rd_ok);

	// head word, new writes show up here one cycle later
	assign rd_data = mem[rd_ptr];

	// ==================================================
	// storage write, no reset on payload
	// ==================================================
	always_ff @(posedge clk) begin
		if (wr_ok) begin
			mem[wr_ptr] <= wr_data;
		end
	end

	// ==================================================
	// pointers, count and flags
	// ==================================================
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			empty  <= 1'b1;
			// reads as full during reset so in_ready stays low
			full   <= 1'b1;
		end else begin
			// pointers wrap naturally, depth is a power of two
			if (wr_ok) begin
				wr_ptr <= wr_ptr + PTR_W'(1);
			end
			if (rd_ok) begin
				rd_ptr <= rd_ptr + PTR_W'(1);
			end
			count <= count_next;
			empty <= (count_next == '0);
			full  <= (count_next == DEPTH_CNT);
		end
	end

endmodule

`default_nettype wire

/* port/port_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// port controller
// decodes the FIFO head, drops illegal packets, requests the bus for the rest
module port_ctrl import packet_pkg::*, switch_ctrl_pkg::*; (
	input  wire logic    clk,
	input  wire logic    rst_n,
	input  wire packet_t head,
	input  wire logic    fifo_empty,
	output logic         rd_en,
	output state_t       state,
	port_if.ctrl         bus
);

	state_t state_next;

	// decode results for the head packet
	logic                  legal;
	logic [`NUM_PORTS-1:0] eff_dest;

	// ==================================================
	// header decode
	// ==================================================
	always_comb begin
		legal    = 1'b0;
		eff_dest = head.target;
		case (head.ptype)
			// broadcast ignores target, goes everywhere but home
			BDP: begin
				legal    = 1'b1;
				eff_dest = ~head.source;
			end
			// no loopback, and at least one target
			DATA, CTRL: begin
				legal = ((head.source & head.target) == '0) && (head.target != '0);
			end
			// reserved type is never routed
			default: begin
				legal = 1'b0;
			end
		endcase
	end

	// interface outputs
	assign bus.req  = (state == ARB_WAIT);
	assign bus.dest = eff_dest;
	assign bus.pkt  = head;

	// ==================================================
	// port FSM
	// ==================================================
	always_comb begin
		state_next = state;
		rd_en      = 1'b0;
		case (state)
			IDLE: begin
				if (!fifo_empty) begin
					state_next = ROUTE;
				end
			end
			ROUTE: begin
				// illegal head is popped here and never requests
				if (!legal) begin
					rd_en      = 1'b1;
					state_next = IDLE;
				end else begin
					state_next = ARB_WAIT;
				end
			end
			ARB_WAIT: begin
				// pop on the grant cycle, crossbar samples head on this edge
				if (bus.grant) begin
					rd_en      = 1'b1;
					state_next = TRANSMIT;
				end
			end
			TRANSMIT: begin
				state_next = IDLE;
			end
			default: begin
				state_next = IDLE;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

endmodule

`default_nettype wire

/* source/crossbar_out.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// registered output stage
// copies the granted packet to every port in its destination mask
module crossbar_out import packet_pkg::*; (
	input  wire logic                    clk,
	input  wire logic                    rst_n,
	port_if.xbar                         p0,
	port_if.xbar                         p1,
	port_if.xbar                         p2,
	port_if.xbar                         p3,
	output logic [`NUM_PORTS-1:0]        out_valid,
	output packet_t [`NUM_PORTS-1:0]     out_data
);

	// granted source, mask stays zero when nobody is granted
	packet_t               sel_pkt;
	logic [`NUM_PORTS-1:0] sel_dest;

	// ==================================================
	// source select
	// ==================================================
	always_comb begin
		sel_pkt  = p0.pkt;
		sel_dest = '0;
		// grant is one-hot so the order here does not matter
		if (p0.grant) begin
			sel_pkt  = p0.pkt;
			sel_dest = p0.dest;
		end else if (p1.grant) begin
			sel_pkt  = p1.pkt;
			sel_dest = p1.dest;
		end else if (p2.grant) begin
			sel_pkt  = p2.pkt;
			sel_dest = p2.dest;
		end else if (p3.grant) begin
			sel_pkt  = p3.pkt;
			sel_dest = p3.dest;
		end
	end

	// ==================================================
	// output registers
	// ==================================================

	// valid pulses for one cycle, the cycle after the grant
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= '0;
		end else begin
			out_valid <= sel_dest;
		end
	end

	// data only moves on outputs that receive something
	always_ff @(posedge clk) begin
		for (int j = 0; j < `NUM_PORTS; j++) begin
			if (sel_dest[j]) begin
				out_data[j] <= sel_pkt;
			end
		end
	end

endmodule

`default_nettype wire

/* source/rr_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// round-robin arbiter, one grant per cycle
// grant is combinational from req, only the priority pointer is stored
module rr_arbiter (
	input  wire logic clk,
	input  wire logic rst_n,
	port_if.arb       p0,
	port_if.arb       p1,
	port_if.arb       p2,
	port_if.arb       p3
);

	localparam int PTR_W = $clog2(`NUM_PORTS);

	logic [`NUM_PORTS-1:0] req;
	logic [`NUM_PORTS-1:0] grant;

	// port with highest priority this cycle
	logic [PTR_W-1:0] ptr;

	// search results
	logic [PTR_W-1:0] scan_idx;
	logic [PTR_W-1:0] win_idx;
	logic             win_found;

	assign req = {p3.req, p2.req, p1.req, p0.req};

	// ==================================================
	// search from ptr upward, wrapping
	// ==================================================
	always_comb begin
		win_found = 1'b0;
		win_idx   = ptr;
		scan_idx  = ptr;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			scan_idx = ptr + PTR_W'(i);
			// first requester in rotated order wins
			if (!win_found && req[scan_idx]) begin
				win_found = 1'b1;
				win_idx   = scan_idx;
			end
		end
	end

	// one-hot or zero
	always_comb begin
		grant = '0;
		if (win_found) begin
			grant[win_idx] = 1'b1;
		end
	end

	assign p0.grant = grant[0];
	assign p1.grant = grant[1];
	assign p2.grant = grant[2];
	assign p3.grant = grant[3];

	// winner drops to lowest priority, which bounds every wait
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ptr <= '0;
		end else if (win_found) begin
			ptr <= win_idx + PTR_W'(1);
		end
	end

endmodule

`default_nettype wire

/* source/switch_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// four-port packet switch
// per port: FIFO and controller, shared arbiter and crossbar
module switch_top import packet_pkg::*, switch_ctrl_pkg::*; (
	input  wire logic                                clk,
	input  wire logic                                rst_n,
	input  wire logic [`NUM_PORTS-1:0]               in_valid,
	input  wire logic [`NUM_PORTS-1:0][`PKT_WIDTH-1:0] in_data,
	output logic [`NUM_PORTS-1:0]                    in_ready,
	output logic [`NUM_PORTS-1:0]                    out_valid,
	output logic [`NUM_PORTS-1:0][`PKT_WIDTH-1:0]    out_data
);

	// ==================================================
	// per-port wiring
	// ==================================================

	// FIFO side
	packet_t [`NUM_PORTS-1:0]       fifo_head;
	logic [`NUM_PORTS-1:0]          fifo_empty;
	logic [`NUM_PORTS-1:0]          fifo_full;
	logic [`NUM_PORTS-1:0]          fifo_rd;
	logic [`NUM_PORTS-1:0][3:0]     fifo_count;

	// controller side, also watched by the checkers
	state_t                         port_state [`NUM_PORTS];
	logic [`NUM_PORTS-1:0]          port_req;
	logic [`NUM_PORTS-1:0]          port_grant;

	port_if pif [`NUM_PORTS] ();

	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
		packet_fifo i_fifo (
			.clk     (clk),
			.rst_n   (rst_n),
			.wr_en   (in_valid[i]),
			.wr_data (packet_t'(in_data[i])),
			.rd_en   (fifo_rd[i]),
			.rd_data (fifo_head[i]),
			.empty   (fifo_empty[i]),
			.full    (fifo_full[i]),
			.count   (fifo_count[i])
		);

		port_ctrl i_ctrl (
			.clk        (clk),
			.rst_n      (rst_n),
			.head       (fifo_head[i]),
			.fifo_empty (fifo_empty[i]),
			.rd_en      (fifo_rd[i]),
			.state      (port_state[i]),
			.bus        (pif[i])
		);

		// source may push whenever there is room
		assign in_ready[i]   = ~fifo_full[i];
		assign port_req[i]   = pif[i].req;
		assign port_grant[i] = pif[i].grant;
	end

	// ==================================================
	// shared arbiter and output stage
	// ==================================================
	rr_arbiter i_arb (
		.clk   (clk),
		.rst_n (rst_n),
		.p0    (pif[0]),
		.p1    (pif[1]),
		.p2    (pif[2]),
		.p3    (pif[3])
	);

	crossbar_out i_xbar (
		.clk       (clk),
		.rst_n     (rst_n),
		.p0        (pif[0]),
		.p1        (pif[1]),
		.p2        (pif[2]),
		.p3        (pif[3]),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

endmodule

`default_nettype wire

/* verification/switch_assertions.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// protocol checks on the switch internals
// FIFO flags, port FSM, arbiter grants and reset values
module switch_assertions import packet_pkg::*, switch_ctrl_pkg::*; (
	input  wire logic                             clk,
	input  wire logic                             rst_n,
	input  wire logic [`NUM_PORTS-1:0]            fifo_empty,
	input  wire logic [`NUM_PORTS-1:0][3:0]       fifo_count,
	input  wire logic [`NUM_PORTS-1:0]            fifo_rd,
	input  wire packet_t [`NUM_PORTS-1:0]         fifo_head,
	input  wire state_t                           port_state [`NUM_PORTS],
	input  wire logic [`NUM_PORTS-1:0]            port_req,
	input  wire logic [`NUM_PORTS-1:0]            port_grant,
	input  wire logic [`NUM_PORTS-1:0]            in_ready,
	input  wire logic [`NUM_PORTS-1:0]            out_valid
);

	// failures so far, the testbench reads this
	int unsigned fail_cnt = 0;
	event        fired;

	// cycles each requester has waited without a grant
	int unsigned           wait_cnt [`NUM_PORTS];
	logic [`NUM_PORTS-1:0] head_legal;
	logic                  all_idle;

	always @(fired) fail_cnt = fail_cnt + 1;

	// legality of each head by the routing rules
	always_comb begin
		all_idle = 1'b1;
		for (int i = 0; i < `NUM_PORTS; i++) begin
			case (fifo_head[i].ptype)
				BDP:     head_legal[i] = 1'b1;
				RSVD:    head_legal[i] = 1'b0;
				default: head_legal[i] = ((fifo_head[i].target & fifo_head[i].source) == '0)
					&& (fifo_head[i].target != '0);
			endcase
			if (port_state[i] != IDLE) begin
				all_idle = 1'b0;
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				wait_cnt[i] <= 0;
			end
		end else begin
			for (int i = 0; i < `NUM_PORTS; i++) begin
				wait_cnt[i] <= (port_req[i] && !port_grant[i]) ? wait_cnt[i] + 1 : 0;
			end
		end
	end

	// ==================================================
	// shared checks
	// ==================================================

	// everything quiet while reset is held
	a_reset: assert property (@(posedge clk) !rst_n |->
		(in_ready == '0 && out_valid == '0 && port_req == '0 && all_idle))
		else begin $error("outputs or states not at reset values"); -> fired; end

	// at most one grant per cycle
	a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot0(port_grant))
		else begin $error("more than one port granted"); -> fired; end

	// grant goes only to a requester
	a_grant_req: assert property (@(posedge clk) disable iff (!rst_n) (port_grant & ~port_req) == '0)
		else begin $error("grant without request"); -> fired; end

	// no output pulse without a grant on the edge before
	a_out_grant: assert property (@(posedge clk) disable iff (!rst_n)
		(port_grant == '0) |=> (out_valid == '0))
		else begin $error("out_valid without a grant"); -> fired; end

	// ==================================================
	// per-port checks
	// ==================================================
	for (genvar i = 0; i < `NUM_PORTS; i++) begin : g_port
		// no underflow
		a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
			fifo_rd[i] |-> !fifo_empty[i])
			else begin $error("read from empty FIFO"); -> fired; end

		// count and empty flag agree
		a_count_empty: assert property (@(posedge clk) disable iff (!rst_n)
			(fifo_count[i] == 4'd0) == fifo_empty[i])
			else begin $error("FIFO count and empty disagree"); -> fired; end

		// pop only for a granted transmit or an illegal head in ROUTE
		a_rd_reason: assert property (@(posedge clk) disable iff (!rst_n)
			fifo_rd[i] |-> ((port_state[i] == ARB_WAIT && port_grant[i])
				|| (port_state[i] == ROUTE && !head_legal[i])))
			else begin $error("FIFO read outside grant or drop"); -> fired; end

		// ARB_WAIT is left only on a grant
		a_wait_hold: assert property (@(posedge clk) disable iff (!rst_n)
			(port_state[i] == ARB_WAIT && !port_grant[i]) |=> (port_state[i] == ARB_WAIT))
			else begin $error("port left ARB_WAIT without grant"); -> fired; end

		// bounded wait for every requester
		a_fair: assert property (@(posedge clk) disable iff (!rst_n) wait_cnt[i] < `FAIR_BOUND)
			else begin $error("request starved past the fairness bound"); -> fired; end
	end

endmodule

bind switch_top switch_assertions i_assert (
	.clk        (clk),
	.rst_n      (rst_n),
	.fifo_empty (fifo_empty),
	.fifo_count (fifo_count),
	.fifo_rd    (fifo_rd),
	.fifo_head  (fifo_head),
	.port_state (port_state),
	.port_req   (port_req),
	.port_grant (port_grant),
	.in_ready   (in_ready),
	.out_valid  (out_valid)
);

`default_nettype wire

/* verification/switch_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "switch_defs.svh"

// testbench for the four-port switch
// random traffic per port, outputs compared against per-pair expectation queues
module switch_tb import packet_pkg::*, switch_ctrl_pkg::*; ();

	localparam int CLK_PERIOD = 100;
	localparam int RST_CYCLES = 8;
	localparam int DRIVE_DLY  = 10;
	localparam int NP         = `NUM_PORTS;
	// 24 unicast, 8 broadcast, 16 drop mix, 32 flood, 12 back-pressure
	localparam int TOTAL_PKTS = 92;

	logic                          clk;
	logic                          rst_n;
	logic [NP-1:0]                 in_valid;
	logic [NP-1:0][`PKT_WIDTH-1:0] in_data;
	logic [NP-1:0]                 in_ready;
	logic [NP-1:0]                 out_valid;
	logic [NP-1:0][`PKT_WIDTH-1:0] out_data;

	// words waiting to be offered and the idle gap after each
	packet_t tx_q  [NP][$];
	int      gap_q [NP][$];
	// expected words, index src*NP+dst
	packet_t exp_q [NP*NP][$];

	int          gap_cnt   [NP] = '{default: 0};
	int          stall_cnt [NP] = '{default: 0};
	logic [NP-1:0] rdy_seen;
	logic [31:0] rng = 32'd47;
	int          errors = 0;
	int          errs_at_start = 0;
	int          tests_run = 0;
	int          tests_failed = 0;

	switch_top i_dut (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_data   (in_data),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_data  (out_data)
	);

	// LCG step, value in [0, range)
	function automatic int unsigned rand_u(input int unsigned range);
		rng = rng * 32'd1664525 + 32'd1013904223;
		return (rng >> 8) % range;
	endfunction

	// destination mask by the routing rules, zero when dropped
	function automatic logic [NP-1:0] route_mask(input packet_t p);
		if (p.ptype == RSVD) return '0;
		if (p.ptype == BDP) return ~p.source;
		if ((p.target & p.source) != '0 || p.target == '0) return '0;
		return p.target;
	endfunction

	// random nonzero target without the source port
	function automatic logic [NP-1:0] legal_target(input int src);
		logic [NP-1:0] t;
		t = NP'(rand_u(16)) & ~NP'(1 << src);
		if (t == '0) t = NP'(1 << ((src + 1) % NP));
		return t;
	endfunction

	function automatic int total_errors();
		return errors + int'(i_dut.i_assert.fail_cnt);
	endfunction

	task automatic push_pkt(input int src, input pkt_type_t t, input logic [NP-1:0] tgt,
		input int gap);
		packet_t p;
		p.ptype   = t;
		p.payload = 6'(rand_u(64));
		p.target  = tgt;
		p.source  = NP'(1 << src);
		tx_q[src].push_back(p);
		gap_q[src].push_back(gap);
	endtask

	// accepted word goes to every port it should reach
	task automatic expect_pkt(input int src, input packet_t p);
		logic [NP-1:0] m;
		m = route_mask(p);
		for (int j = 0; j < NP; j++) begin
			if (m[j]) exp_q[src*NP + j].push_back(p);
		end
	endtask

	task automatic check_out(input int dst, input packet_t got);
		int      src;
		packet_t exp;
		src = -1;
		for (int s = 0; s < NP; s++) begin
			if (got.source == NP'(1 << s)) src = s;
		end
		if (src < 0) begin
			$display("error at %0t ns: port %0d delivered %h with no valid source", $time, dst, got);
			errors++;
		end else if (exp_q[src*NP + dst].size() == 0) begin
			$display("error at %0t ns: port %0d delivered unexpected %h", $time, dst, got);
			errors++;
		end else begin
			exp = exp_q[src*NP + dst].pop_front();
			if (got !== exp) begin
				$display("Mismatch at %0t ns: port %0d from port %0d expected %h, got %h",
					$time, dst, src, exp, got);
				errors++;
			end
		end
	endtask

	// wait until all queues are empty and the switch is quiet
	task automatic wait_drain();
		logic busy;
		busy = 1'b1;
		while (busy) begin
			@(posedge clk);
			#(3*DRIVE_DLY);
			busy = (in_valid != '0) || (out_valid != '0) || (i_dut.fifo_empty != '1);
			for (int p = 0; p < NP; p++) begin
				busy |= (tx_q[p].size() > 0) || (i_dut.port_state[p] != IDLE);
			end
			for (int k = 0; k < NP*NP; k++) begin
				busy |= (exp_q[k].size() > 0);
			end
		end
	endtask

	task automatic end_test(input string name);
		int n;
		n = total_errors() - errs_at_start;
		tests_run++;
		if (n > 0) tests_failed++;
		$display("test %-12s %s (%0d errors)", name, (n > 0) ? "FAILED" : "ok", n);
		errs_at_start = total_errors();
	endtask

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD/2) clk = ~clk;
	end

	// ==================================================
	// input driver and output monitor, once per cycle
	// ==================================================
	initial begin
		in_valid = '0;
		in_data  = '0;
		rdy_seen = '0;
		forever begin
			@(posedge clk);
			#DRIVE_DLY;
			for (int j = 0; j < NP; j++) begin
				if (out_valid[j]) check_out(j, out_data[j]);
			end
			for (int p = 0; p < NP; p++) begin
				// offered across the last edge with room, so taken
				if (in_valid[p] && rdy_seen[p]) begin
					expect_pkt(p, tx_q[p].pop_front());
					gap_cnt[p]  = gap_q[p].pop_front();
					in_valid[p] = 1'b0;
				end
				if (!in_valid[p]) begin
					if (gap_cnt[p] > 0) begin
						gap_cnt[p]--;
					end else if (tx_q[p].size() > 0) begin
						in_valid[p] = 1'b1;
						in_data[p]  = tx_q[p][0];
					end
				end
				if (in_valid[p] && !in_ready[p]) stall_cnt[p]++;
				rdy_seen[p] = in_ready[p];
			end
		end
	end

	// watchdog
	initial begin
		#((TOTAL_PKTS * `FAIR_BOUND * NP + RST_CYCLES) * CLK_PERIOD);
		$display("timeout: the switch did not deliver all packets in time");
		$display("Simulation finished: FAIL");
		$finish;
	end

	// ==================================================
	// test sequence
	// ==================================================
	initial begin
		int        src;
		int        stalls;
		pkt_type_t t;
		rst_n = 1'b1;
		#5;
		rst_n = 1'b0;
		repeat (RST_CYCLES) @(posedge clk);
		#DRIVE_DLY;
		if (in_ready != '0) begin
			$display("error at %0t ns: in_ready high during reset", $time);
			errors++;
		end
		rst_n = 1'b1;
		@(posedge clk);
		#(3*DRIVE_DLY);
		if (in_ready != '1 || out_valid != '0) begin
			$display("error at %0t ns: in_ready or out_valid wrong after reset", $time);
			errors++;
		end
		end_test("reset");

		// unicast and multicast with DATA and CTRL
		for (int n = 0; n < 24; n++) begin
			src = rand_u(NP);
			t   = (rand_u(4) == 0) ? CTRL : DATA;
			push_pkt(src, t, legal_target(src), rand_u(3));
		end
		wait_drain();
		end_test("unicast");

		// broadcast ignores the target field
		for (int n = 0; n < 2*NP; n++) begin
			push_pkt(n % NP, BDP, NP'(rand_u(16)), rand_u(2));
		end
		wait_drain();
		end_test("broadcast");

		// loopback, zero target and reserved type mixed with legal traffic
		for (int n = 0; n < 16; n++) begin
			src = rand_u(NP);
			case (n % 4)
				0:       push_pkt(src, DATA, legal_target(src) | NP'(1 << src), rand_u(2));
				1:       push_pkt(src, CTRL, '0, rand_u(2));
				2:       push_pkt(src, RSVD, legal_target(src), rand_u(2));
				default: push_pkt(src, DATA, legal_target(src), rand_u(2));
			endcase
		end
		wait_drain();
		end_test("drop");

		// all ports back to back
		for (int n = 0; n < 8; n++) begin
			for (int p = 0; p < NP; p++) begin
				t = (rand_u(3) == 0) ? BDP : DATA;
				push_pkt(p, t, legal_target(p), 0);
			end
		end
		wait_drain();
		end_test("flood");

		// one port pushed faster than it drains
		stalls = stall_cnt[0];
		for (int n = 0; n < 12; n++) begin
			push_pkt(0, DATA, legal_target(0), 0);
		end
		wait_drain();
		if (stall_cnt[0] == stalls) begin
			$display("error at %0t ns: in_ready on port 0 never fell under back-pressure", $time);
			errors++;
		end
		end_test("backpressure");

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, total_errors());
		if (total_errors() == 0 && tests_failed == 0) begin
			$display("Simulation finished: PASS");
		end else begin
			$display("Simulation finished: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* verilog.f */
+incdir+common
common/packet_pkg.sv
common/switch_ctrl_pkg.sv
common/port_if.sv
port/packet_fifo.sv
port/port_ctrl.sv
source/rr_arbiter.sv
source/crossbar_out.sv
source/switch_top.sv
verification/switch_assertions.sv
verification/switch_tb.sv
